/* snake_game_top.f */
+incdir+design
design/snake_grid_pkg.sv
design/snake_ctrl_pkg.sv
design/scan_if.sv
design/button_conditioner.sv
design/cell_scanner.sv
design/snake_body_controller.sv
design/playfield_renderer.sv
design/snake_game_top.sv
verif/tb_clock_gen.sv
verif/snake_game_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal -f snake_game_top.f --top-module snake_game_tb \
  -o snake_game_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/snake_game_sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"

/* verif/snake_game_tb.sv */
// Snake playfield testbench
`timescale 1ns/1ps
`default_nettype none
`include "snake_params.svh"

module snake_game_tb;
  import snake_grid_pkg::*;
  import snake_ctrl_pkg::*;

  localparam int CYCLE_LIMIT = 20000; // well above the 40 or so frames the tests run

  logic       next_map_a;
  logic       reset;
  logic [5:0] raw_buttons; // map, grow, down, up, left, right
  cell_x_t    cell_x;
  cell_y_t    cell_y;
  cell_obj_t  cell_obj;
  logic       cell_valid;
  logic       frame_sync;
  length_t    length;
  map_index_t map_index;
  logic       game_over;

  // reference model state
  segment_t   m_seg [`MAX_LENGTH];
  dir_t       m_cur;
  dir_t       m_pend;
  length_t    m_len;
  map_index_t m_map;
  logic       m_over;
  cell_x_t    m_x;
  cell_y_t    m_y;
  logic       m_end;
  logic       m_scan_vld;
  logic       m_vld;
  int         ev_tag [$]; // edge at which a press lands
  int         ev_btn [$];
  int         cyc;
  int         seed;

  tb_clock_gen tb_clock_gen_inst (
    .next_map_a (next_map_a),
    .reset      (reset)
  );

  snake_game_top snake_game_top_inst (
    .next_map_a  (next_map_a),
    .reset       (reset),
    .dir_button  (raw_buttons[3:0]),
    .grow_button (raw_buttons[4]),
    .map_button  (raw_buttons[5]),
    .cell_x      (cell_x),
    .cell_y      (cell_y),
    .cell_obj    (cell_obj),
    .cell_valid  (cell_valid),
    .frame_sync  (frame_sync),
    .length      (length),
    .map_index   (map_index),
    .game_over   (game_over)
  );

  function automatic logic on_border(int x, int y);
    return x == 0 || x == `GRID_W - 1 || y == 0 || y == `GRID_H - 1;
  endfunction

  function automatic dir_t reverse_of(dir_t d);
    case (d)
      RIGHT:   return LEFT;
      LEFT:    return RIGHT;
      UP:      return DOWN;
      default: return UP;
    endcase
  endfunction

  function automatic segment_t step_head(segment_t s, dir_t d);
    segment_t n;
    n = s;
    case (d)
      RIGHT:   n.x = s.x + 4'd1;
      LEFT:    n.x = s.x - 4'd1;
      UP:      n.y = s.y - 4'd1;
      default: n.y = s.y + 4'd1;
    endcase
    return n;
  endfunction

  function automatic cell_obj_t expected_obj(cell_x_t x, cell_y_t y);
    segment_t here;
    here = '{x: x, y: y};
    if (m_seg[0] == here) return HEAD;
    for (int i = 1; i < int'(m_len); i++) begin
      if (m_seg[i] == here) return BODY;
    end
    // apple walks over the interior columns as the map advances
    if (int'(y) == `APPLE_Y && int'(x) == 1 + (`APPLE_BASE_X - 1 + int'(m_map)) % (`GRID_W - 2))
      return APPLE;
    if (on_border(x, y)) return BORDER;
    return EMPTY;
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `MAX_LENGTH; i++) begin
      m_seg[i] = '{x: cell_x_t'(`START_HEAD_X - 2), y: cell_y_t'(`START_HEAD_Y)};
    end
    m_seg[0] = '{x: cell_x_t'(`START_HEAD_X), y: cell_y_t'(`START_HEAD_Y)};
    m_seg[1] = '{x: cell_x_t'(`START_HEAD_X - 1), y: cell_y_t'(`START_HEAD_Y)};
    m_cur  = RIGHT;
    m_pend = RIGHT;
    m_len  = length_t'(`START_LENGTH);
    m_map  = '0;
    m_over = 1'b0;
    m_x    = '0;
    m_y    = '0;
    m_scan_vld = 1'b0;
    m_vld      = 1'b0;
  endtask

  // one model clock edge with presses applied before the frame move
  task automatic apply_edge(logic frame_end);
    dir_t next_pend;
    next_pend = m_pend;
    while (ev_tag.size() > 0 && ev_tag[0] <= cyc - 1) begin
      if (ev_btn[0] < 4) begin
        if (dir_t'(ev_btn[0]) != reverse_of(m_cur)) next_pend = dir_t'(ev_btn[0]);
      end else if (ev_btn[0] == 4) begin
        if (m_len < `MAX_LENGTH) m_len = length_t'(m_len + 1);
      end else begin
        m_map = map_index_t'(m_map + 1);
      end
      void'(ev_tag.pop_front());
      void'(ev_btn.pop_front());
    end
    if (frame_end && !m_over) begin
      for (int i = `MAX_LENGTH - 1; i > 0; i--) begin
        m_seg[i] = m_seg[i-1];
      end
      m_seg[0] = step_head(m_seg[0], m_pend);
      m_cur    = m_pend;
      m_over   = on_border(m_seg[0].x, m_seg[0].y);
    end
    m_pend = next_pend;
  endtask

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(string msg);
    $display("** Error at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_cell(cell_obj_t got, cell_obj_t exp);
    if (got !== exp)
      report_mismatch($sformatf("cell (%0d,%0d) is %s, expected %s",
                                m_x, m_y, got.name(), exp.name()));
  endtask

  task automatic check_length(length_t got, length_t exp);
    if (got !== exp) report_mismatch($sformatf("length %0d, expected %0d", got, exp));
  endtask

  task automatic check_map(map_index_t got, map_index_t exp);
    if (got !== exp) report_mismatch($sformatf("map_index %0d, expected %0d", got, exp));
  endtask

  task automatic check_game_over(logic got, logic exp);
    if (got !== exp) report_mismatch($sformatf("game_over %b, expected %b", got, exp));
  endtask

  // compare against the state behind the output before advancing the model
  always @(posedge next_map_a) begin
    if (reset) begin
      reset_model();
    end else begin
      if (cell_valid !== m_vld)
        report_mismatch($sformatf("cell_valid %b, expected %b", cell_valid, m_vld));
      m_end = m_vld && m_x == cell_x_t'(`GRID_W - 1) && m_y == cell_y_t'(`GRID_H - 1);
      if (m_vld) begin
        if (cell_x !== m_x || cell_y !== m_y || frame_sync !== m_end)
          report_mismatch($sformatf("scan (%0d,%0d) sync %b, expected (%0d,%0d) sync %b",
                                    cell_x, cell_y, frame_sync, m_x, m_y, m_end));
        check_cell(cell_obj, expected_obj(m_x, m_y));
        if (m_x == cell_x_t'(`GRID_W - 1)) begin
          m_x = '0;
          m_y = (m_y == cell_y_t'(`GRID_H - 1)) ? '0 : m_y + 4'd1;
        end else begin
          m_x = m_x + 4'd1;
        end
      end
      m_vld      = m_scan_vld; // outputs trail the scan by one cycle
      m_scan_vld = 1'b1;
      apply_edge(m_end);
      check_length(length, m_len);
      check_map(map_index, m_map);
      check_game_over(game_over, m_over);
    end
  end

  initial begin
    cyc = 0;
    forever begin
      @(negedge next_map_a);
      cyc = cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
        $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
        stop_run();
      end
    end
  end

  // held high 4 cycles and low 4 cycles
  task automatic press_button(int btn);
    @(posedge next_map_a);
    raw_buttons <= 6'(1) << btn;
    ev_tag.push_back(cyc + 4); // lands 4 edges after the rise
    ev_btn.push_back(btn);
    repeat (4) @(posedge next_map_a);
    raw_buttons <= '0;
    repeat (3) @(posedge next_map_a);
  endtask

  task automatic wait_frame_start();
    do @(posedge next_map_a); while (frame_sync !== 1'b1);
  endtask

  // press the wished direction or the next one that keeps the head inside
  task automatic steer_safely(int wish);
    dir_t     d;
    dir_t     eff;
    segment_t nxt;
    @(negedge next_map_a);
    for (int k = 0; k < 4; k++) begin
      d   = dir_t'((wish + k) % 4);
      eff = (d == reverse_of(m_cur)) ? m_cur : d;
      nxt = step_head(m_seg[0], eff);
      if (!on_border(nxt.x, nxt.y)) break;
    end
    press_button(int'(d));
  endtask

  initial begin
    int wish;
    raw_buttons = '0;
    seed = 71882;
    @(negedge reset);
    repeat (4) wait_frame_start(); // reset image and straight moves to the right
    wait_frame_start();
    steer_safely(int'(UP));
    wait_frame_start();
    steer_safely(int'(DOWN)); // reverse of up is ignored
    repeat (12) begin
      wait_frame_start();
      wish = $random(seed);
      steer_safely(wish & 3);
    end
    repeat (3) begin // 48 grow presses saturate the length at 50
      wait_frame_start();
      wish = $random(seed);
      steer_safely(wish & 3);
      repeat (16) press_button(4);
    end
    wait_frame_start();
    wish = $random(seed);
    steer_safely(wish & 3);
    repeat (17) press_button(5); // map index wraps past 15
    while (m_over !== 1'b1) begin // without turns the head runs into the wall
      wait_frame_start();
      @(negedge next_map_a);
    end
    repeat (3) begin
      wait_frame_start();
      wish = $random(seed);
      steer_safely(wish & 3);
    end
    wait_frame_start();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic next_map_a,
  output logic reset
);

  initial begin
    next_map_a = 1'b0;
    forever #10 next_map_a = ~next_map_a; // 20 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge next_map_a);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* design/snake_game_top.sv */
// Snake playfield top level
`timescale 1ns/1ps
`default_nettype none

module snake_game_top (
  input  logic                       next_map_a,
  input  logic                       reset,
  input  logic [3:0]                 dir_button, // right, left, up, down
  input  logic                       grow_button,
  input  logic                       map_button,
  output snake_grid_pkg::cell_x_t    cell_x,
  output snake_grid_pkg::cell_y_t    cell_y,
  output snake_grid_pkg::cell_obj_t  cell_obj,
  output logic                       cell_valid,
  output logic                       frame_sync,
  output snake_ctrl_pkg::length_t    length,
  output snake_ctrl_pkg::map_index_t map_index,
  output logic                       game_over
);

  logic [5:0] press;
  logic       head_hit;
  logic       body_hit;

  scan_if scan_bus ();

  button_conditioner button_conditioner_inst (
    .next_map_a (next_map_a),
    .reset      (reset),
    .raw        ({map_button, grow_button, dir_button}),
    .press      (press)
  );

  cell_scanner cell_scanner_inst (
    .next_map_a (next_map_a),
    .reset      (reset),
    .scan       (scan_bus.scanner)
  );

  snake_body_controller snake_body_controller_inst (
    .next_map_a (next_map_a),
    .reset      (reset),
    .scan       (scan_bus.viewer),
    .dir_press  (press[3:0]),
    .grow_press (press[4]),
    .head_hit   (head_hit),
    .body_hit   (body_hit),
    .length     (length),
    .game_over  (game_over)
  );

  playfield_renderer playfield_renderer_inst (
    .next_map_a (next_map_a),
    .reset      (reset),
    .scan       (scan_bus.viewer),
    .map_press  (press[5]),
    .head_hit   (head_hit),
    .body_hit   (body_hit),
    .map_index  (map_index),
    .cell_x     (cell_x),
    .cell_y     (cell_y),
    .cell_obj   (cell_obj),
    .cell_valid (cell_valid),
    .frame_sync (frame_sync)
  );

endmodule

`default_nettype wire

/* design/playfield_renderer.sv */
// Playfield renderer
`timescale 1ns/1ps
`default_nettype none
`include "snake_params.svh"

module playfield_renderer (
  input  logic                       next_map_a,
  input  logic                       reset,
  scan_if.viewer                     scan,
  input  logic                       map_press,
  input  logic                       head_hit,
  input  logic                       body_hit,
  output snake_ctrl_pkg::map_index_t map_index,
  output snake_grid_pkg::cell_x_t    cell_x,
  output snake_grid_pkg::cell_y_t    cell_y,
  output snake_grid_pkg::cell_obj_t  cell_obj,
  output logic                       cell_valid,
  output logic                       frame_sync
);
  import snake_grid_pkg::*;
  import snake_ctrl_pkg::*;

  logic [4:0] apple_sum;
  cell_x_t    apple_x;
  logic       border;
  logic       apple;
  cell_obj_t  obj;

  // apple column cycles through the interior columns 1..14
  assign apple_sum = 5'(`APPLE_BASE_X) + 5'(map_index);
  assign apple_x   = (apple_sum > 5'(`GRID_W - 2)) ? cell_x_t'(apple_sum - 5'(`GRID_W - 2))
                                                   : cell_x_t'(apple_sum);

  assign border = (scan.x == '0) || (scan.x == cell_x_t'(`GRID_W - 1)) ||
                  (scan.y == '0) || (scan.y == cell_y_t'(`GRID_H - 1));
  assign apple  = (scan.x == apple_x) && (scan.y == cell_y_t'(`APPLE_Y));

  always_comb begin
    if (head_hit)      obj = HEAD;
    else if (body_hit) obj = BODY;
    else if (apple)    obj = APPLE;
    else if (border)   obj = BORDER;
    else               obj = EMPTY;
  end

  always_ff @(posedge next_map_a or posedge reset) begin
    if (reset) begin
      map_index  <= '0;
      cell_valid <= 1'b0;
      frame_sync <= 1'b0;
    end else begin
      if (map_press) map_index <= map_index + 1'b1; // wraps 15 -> 0
      cell_valid <= scan.valid;
      frame_sync <= scan.frame_end;
    end
  end

  always_ff @(posedge next_map_a) begin
    cell_x   <= scan.x;
    cell_y   <= scan.y;
    cell_obj <= obj;
  end

endmodule

`default_nettype wire

/* design/snake_body_controller.sv */
// Snake body controller
`timescale 1ns/1ps
`default_nettype none
`include "snake_params.svh"

module snake_body_controller (
  input  logic                    next_map_a,
  input  logic                    reset,
  scan_if.viewer                  scan,
  input  logic [3:0]              dir_press,
  input  logic                    grow_press,
  output logic                    head_hit,
  output logic                    body_hit,
  output snake_ctrl_pkg::length_t length,
  output logic                    game_over
);
  import snake_grid_pkg::*;
  import snake_ctrl_pkg::*;

  segment_t seg [`MAX_LENGTH]; // slot 0 is the head
  segment_t next_head;
  segment_t scan_seg;
  dir_t     cur_dir;
  dir_t     pend_dir;
  dir_t     req_dir;
  logic     req_ok;
  logic     head_on_border;

  // lowest pressed bit wins
  always_comb begin
    req_dir = RIGHT;
    req_ok  = 1'b0;
    for (int i = 3; i >= 0; i--) begin
      if (dir_press[i]) begin
        req_dir = dir_t'(i);
        req_ok  = 1'b1;
      end
    end
    if (req_dir == dir_t'(cur_dir ^ 2'd1)) req_ok = 1'b0; // no reversing
  end

  always_comb begin
    next_head = seg[0];
    case (pend_dir)
      RIGHT:   next_head.x = seg[0].x + 1'b1;
      LEFT:    next_head.x = seg[0].x - 1'b1;
      UP:      next_head.y = seg[0].y - 1'b1;
      default: next_head.y = seg[0].y + 1'b1;
    endcase
  end

  assign head_on_border = (next_head.x == '0) || (next_head.x == cell_x_t'(`GRID_W - 1)) ||
                          (next_head.y == '0) || (next_head.y == cell_y_t'(`GRID_H - 1));

  always_ff @(posedge next_map_a or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `MAX_LENGTH; i++) begin
        seg[i] <= '{x: cell_x_t'(`START_HEAD_X - 2), y: cell_y_t'(`START_HEAD_Y)};
      end
      seg[0]    <= '{x: cell_x_t'(`START_HEAD_X), y: cell_y_t'(`START_HEAD_Y)};
      seg[1]    <= '{x: cell_x_t'(`START_HEAD_X - 1), y: cell_y_t'(`START_HEAD_Y)};
      cur_dir   <= RIGHT;
      pend_dir  <= RIGHT;
      length    <= length_t'(`START_LENGTH);
      game_over <= 1'b0;
    end else begin
      if (req_ok) pend_dir <= req_dir;
      if (grow_press && length < length_t'(`MAX_LENGTH)) length <= length + 1'b1;
      if (scan.frame_end && !game_over) begin
        cur_dir <= pend_dir;
        for (int i = `MAX_LENGTH - 1; i > 0; i--) begin
          seg[i] <= seg[i-1];
        end
        seg[0] <= next_head;
        if (head_on_border) game_over <= 1'b1; // sticky until reset
      end
    end
  end

  assign scan_seg = '{x: scan.x, y: scan.y};
  assign head_hit = (seg[0] == scan_seg);

  // only slots below the current length count
  always_comb begin
    body_hit = 1'b0;
    for (int i = 1; i < `MAX_LENGTH; i++) begin
      if (length_t'(i) < length && seg[i] == scan_seg) body_hit = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/cell_scanner.sv */
// Raster cell scanner
`timescale 1ns/1ps
`default_nettype none
`include "snake_params.svh"

module cell_scanner (
  input  logic next_map_a,
  input  logic reset,
  scan_if.scanner scan
);
  import snake_grid_pkg::*;

  logic last_x;
  logic last_y;

  assign last_x = (scan.x == cell_x_t'(`GRID_W - 1));
  assign last_y = (scan.y == cell_y_t'(`GRID_H - 1));

  assign scan.frame_end = scan.valid && last_x && last_y;

  always_ff @(posedge next_map_a or posedge reset) begin
    if (reset) begin
      scan.x     <= '0;
      scan.y     <= '0;
      scan.valid <= 1'b0;
    end else begin
      scan.valid <= 1'b1;
      if (scan.valid) begin // hold at 0,0 for the first cycle
        if (last_x) begin
          scan.x <= '0;
          scan.y <= last_y ? '0 : scan.y + 1'b1;
        end else begin
          scan.x <= scan.x + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/button_conditioner.sv */
// Button synchronizer and edge detect
`timescale 1ns/1ps
`default_nettype none
`include "snake_params.svh"

module button_conditioner (
  input  logic       next_map_a,
  input  logic       reset,
  input  logic [5:0] raw,
  output logic [5:0] press
);

  logic [5:0] sync_q [`SYNC_STAGES];
  logic [5:0] prev_q; // edge register

  always_ff @(posedge next_map_a or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      prev_q <= '0;
      press  <= '0;
    end else begin
      sync_q[0] <= raw;
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      prev_q <= sync_q[`SYNC_STAGES-1];
      press  <= sync_q[`SYNC_STAGES-1] & ~prev_q; // rising edges only
    end
  end

endmodule

`default_nettype wire

/* design/scan_if.sv */
// Scan position bus
`timescale 1ns/1ps
`default_nettype none

interface scan_if;
  import snake_grid_pkg::*;

  cell_x_t x;
  cell_y_t y;
  logic    valid;
  logic    frame_end; // last cell of the frame

  modport scanner (output x, y, valid, frame_end);
  modport viewer  (input x, y, valid, frame_end);

endinterface

`default_nettype wire

/* design/snake_ctrl_pkg.sv */
// Game control types
`default_nettype none

package snake_ctrl_pkg;

  // reverse of a direction is the value with bit 0 flipped
  typedef enum logic [1:0] {
    RIGHT = 2'd0,
    LEFT  = 2'd1,
    UP    = 2'd2,
    DOWN  = 2'd3
  } dir_t;

  typedef logic [6:0] length_t;    // up to MAX_LENGTH
  typedef logic [3:0] map_index_t; // wraps at 16

endpackage

`default_nettype wire

/* design/snake_grid_pkg.sv */
// Grid types
`default_nettype none

package snake_grid_pkg;

  typedef logic [3:0] cell_x_t; // column
  typedef logic [3:0] cell_y_t; // row

  // one snake segment, x in the upper nibble
  typedef struct packed {
    cell_x_t x;
    cell_y_t y;
  } segment_t;

  // object codes seen on the cell output
  typedef enum logic [2:0] {
    EMPTY  = 3'd0,
    BORDER = 3'd1,
    APPLE  = 3'd2,
    BODY   = 3'd3,
    HEAD   = 3'd4
  } cell_obj_t;

endpackage

`default_nettype wire

/* design/snake_params.svh */
// Snake game constants
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// playfield size in cells
`define GRID_W 16
`define GRID_H 12

// segment history depth
`define MAX_LENGTH 50
`define START_LENGTH 3

// head position after reset
`define START_HEAD_X 5
`define START_HEAD_Y 4

// apple spot for map 0
`define APPLE_BASE_X 7
`define APPLE_Y 4

`define SYNC_STAGES 2

`endif
